// ==== Makefile ====
# Verilator build and run for the ESP link testbench

VERILATOR ?= verilator
TOP       ?= tb_esp_link
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/esp_link_cfg.svh ====
`ifndef ESP_LINK_CFG_SVH
`define ESP_LINK_CFG_SVH

// Register bank geometry
`define ESP_WORD_W    32  // Bits per register word
`define ESP_ADDR_W    5   // Bits of register address
`define ESP_REG_COUNT 32  // Registers including status at 0

// Link flow control
`define ESP_CREDITS   4   // Queue depth and starting credits

// Status register
`define ESP_COUNT_W   16  // Stored word counter width

`endif

// ==== logic/esp_link_pkg.sv ====
`include "esp_link_cfg.svh"

// Link side view of the subsystem
package esp_link_pkg;

    // One byte from the companion chip per clock
    typedef logic [7:0] esp_byte_t;

    // Assembled word on its way to the bank
    typedef struct packed {
        logic                   valid;  // Push strobe or queue not empty
        logic [`ESP_ADDR_W-1:0] addr;   // Target register
        logic [`ESP_WORD_W-1:0] data;   // First link byte sits in the MSBs
    } word_wr_t;

endpackage

// ==== logic/esp_link_top.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module esp_link_top (
    input  logic                    clk,
    input  logic                    nrst,
    input  esp_link_pkg::esp_byte_t esp_data,
    input  logic                    esp_cs,     // Active low frame select
    input  reg_bus_pkg::host_req_t  host_req,
    output logic                    host_gnt,
    output reg_bus_pkg::host_rsp_t  host_rsp,
    output logic                    link_busy   // Link data not yet in the bank
);
    import esp_link_pkg::*;
    import reg_bus_pkg::*;

    word_wr_t                asm_word;       // Assembler push
    word_wr_t                q_head;         // Oldest queued write
    bank_wr_t                bank_req;
    logic [`ESP_WORD_W-1:0]  rd_data;
    logic                    credit_return;
    logic                    link_grant;
    logic                    overrun;
    logic                    partial;

    esp_word_assembler u_asm (
        .clk           (clk),
        .nrst          (nrst),
        .esp_data      (esp_data),
        .esp_cs        (esp_cs),
        .credit_return (credit_return),
        .word_out      (asm_word),
        .overrun       (overrun),
        .partial       (partial)
    );

    write_credit_queue #(.DEPTH(`ESP_CREDITS)) u_queue (
        .clk           (clk),
        .nrst          (nrst),
        .push          (asm_word),
        .head          (q_head),
        .pop           (link_grant),
        .credit_return (credit_return)
    );

    reg_bank_arbiter u_arb (
        .clk        (clk),
        .nrst       (nrst),
        .link_req   (q_head),
        .link_grant (link_grant),
        .host_req   (host_req),
        .host_gnt   (host_gnt),
        .host_rsp   (host_rsp),
        .bank_req   (bank_req),
        .rd_data    (rd_data)
    );

    reg_bank u_bank (
        .clk              (clk),
        .nrst             (nrst),
        .bank_req         (bank_req),
        .rd_data          (rd_data),
        .link_word_stored (link_grant),  // Every link grant is a stored word
        .overrun          (overrun)
    );

    // Busy while bytes or queued words are still in flight
    assign link_busy = q_head.valid | partial;

endmodule

// ==== logic/esp_word_assembler.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module esp_word_assembler (
    input  logic                    clk,
    input  logic                    nrst,
    input  esp_link_pkg::esp_byte_t esp_data,       // Sampled while esp_cs is low
    input  logic                    esp_cs,         // High aborts the frame
    input  logic                    credit_return,  // One queue slot freed
    output esp_link_pkg::word_wr_t  word_out,       // One cycle push to the queue
    output logic                    overrun,        // Word lost for lack of credit
    output logic                    partial         // Bytes of a word are held
);
    import esp_link_pkg::*;

    localparam int ADDR_W  = `ESP_ADDR_W;
    localparam int CRED_W  = $clog2(`ESP_CREDITS + 1);
    localparam int LAST_AD = `ESP_REG_COUNT - 1;  // Highest link address

    logic [1:0]                 byte_cnt;  // Bytes already held, 0 to 3
    logic [`ESP_WORD_W-9:0]     shift_q;   // Last three bytes, oldest on top
    logic [ADDR_W-1:0]          addr;      // Address of the word in progress
    logic [ADDR_W-1:0]          addr_nxt;
    logic [CRED_W-1:0]          credits;   // Free queue slots
    logic                       word_done;
    logic                       credit_ok;
    logic                       push;
    word_wr_t                   word_q;

    assign word_done = !esp_cs && (byte_cnt == 2'd3);  // Fourth byte on the bus now
    assign credit_ok = (credits != '0);
    assign push      = word_done && credit_ok;

    // Address steps 1 to 31 and skips status on wrap
    assign addr_nxt = (addr == ADDR_W'(LAST_AD)) ? ADDR_W'(1) : addr + ADDR_W'(1);

    // Byte shifter, contents are don't care between words
    always_ff @(posedge clk) begin
        if (!esp_cs) begin
            shift_q <= {shift_q[`ESP_WORD_W-17:0], esp_data};  // Newest byte at the bottom
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            byte_cnt     <= '0;
            addr         <= ADDR_W'(1);               // Frames start at address 1
            credits      <= CRED_W'(`ESP_CREDITS);    // Queue empty so all credits free
            word_q.valid <= 1'b0;
            overrun      <= 1'b0;
        end else begin
            word_q.valid <= push;                     // Pulse for exactly one cycle
            overrun      <= word_done && !credit_ok;  // Dropped word
            if (push) begin
                word_q.addr <= addr;
                word_q.data <= {shift_q, esp_data};   // First byte ends in the MSBs
            end
            // Spend and return may coincide
            credits <= credits - CRED_W'(push) + CRED_W'(credit_return);
            if (esp_cs) begin
                byte_cnt <= '0;                       // Partial word is discarded
                addr     <= ADDR_W'(1);
            end else begin
                byte_cnt <= byte_cnt + 2'd1;          // Wraps to 0 after the fourth byte
                if (word_done) begin
                    addr <= addr_nxt;                 // Advances even on a drop
                end
            end
        end
    end

    assign word_out = word_q;
    assign partial  = (byte_cnt != '0);  // One to three bytes held

endmodule

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module reg_bank (
    input  logic                   clk,
    input  logic                   nrst,
    input  reg_bus_pkg::bank_wr_t  bank_req,          // One access per cycle
    output logic [`ESP_WORD_W-1:0] rd_data,           // Follows bank_req.addr
    input  logic                   link_word_stored,  // Link write granted
    input  logic                   overrun            // Assembler dropped a word
);
    import reg_bus_pkg::*;

    reg_word_t               regs [1:`ESP_REG_COUNT-1];  // Writable registers only
    logic [`ESP_COUNT_W-1:0] word_count;
    logic                    overrun_flag;
    logic                    wr_en;
    status_t                 status;

    // Address 0 is read only
    assign wr_en = bank_req.valid && bank_req.write && (bank_req.addr != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[bank_req.addr] <= bank_req.data;  // Lands on the grant edge
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            word_count   <= '0;
            overrun_flag <= 1'b0;
        end else begin
            if (link_word_stored && (word_count != '1)) begin
                word_count <= word_count + 1'b1;  // Stops at all ones
            end
            if (overrun) begin
                overrun_flag <= 1'b1;             // Cleared only by reset
            end
        end
    end

    always_comb begin
        status            = '0;  // Reserved bits read zero
        status.overrun    = overrun_flag;
        status.word_count = word_count;
    end

    always_comb begin
        if (bank_req.addr == '0) begin
            rd_data = status;
        end else begin
            rd_data = regs[bank_req.addr];
        end
    end

endmodule

// ==== logic/reg_bank_arbiter.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module reg_bank_arbiter (
    input  logic                    clk,
    input  logic                    nrst,
    input  esp_link_pkg::word_wr_t  link_req,    // Queue head
    output logic                    link_grant,  // Pops the queue head
    input  reg_bus_pkg::host_req_t  host_req,
    output logic                    host_gnt,
    output reg_bus_pkg::host_rsp_t  host_rsp,    // Registered read data
    output reg_bus_pkg::bank_wr_t   bank_req,
    input  logic [`ESP_WORD_W-1:0]  rd_data      // Combinational from the bank
);
    import reg_bus_pkg::*;

    logic      last_host;  // Host won the last grant
    logic      lock_hold;  // Host keeps the bank
    logic      host_win;
    logic      link_win;
    bank_wr_t  bank_q;
    host_rsp_t rsp_q;

    always_comb begin
        host_win = 1'b0;
        link_win = 1'b0;
        if (host_req.valid && link_req.valid) begin
            if (lock_hold || !last_host) begin
                host_win = 1'b1;          // Locked or host's turn
            end else begin
                link_win = 1'b1;
            end
        end else begin
            host_win = host_req.valid;    // Lone requester wins
            link_win = link_req.valid;
        end
    end

    // Winner drives the bank, link side only writes
    always_comb begin
        bank_q = '0;
        if (link_win) begin
            bank_q.valid = 1'b1;
            bank_q.write = 1'b1;
            bank_q.addr  = link_req.addr;
            bank_q.data  = link_req.data;
        end else if (host_win) begin
            bank_q.valid = 1'b1;
            bank_q.write = host_req.write;
            bank_q.addr  = host_req.addr;
            bank_q.data  = host_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            last_host   <= 1'b0;
            lock_hold   <= 1'b0;
            rsp_q.valid <= 1'b0;
        end else begin
            if (host_win || link_win) begin
                last_host <= host_win;
            end
            if (host_win) begin
                lock_hold <= host_req.lock;  // Each access renews or ends the lock
            end else if (!host_req.valid) begin
                lock_hold <= 1'b0;           // Host went idle
            end
            rsp_q.valid <= host_win && !host_req.write;
            if (host_win && !host_req.write) begin
                rsp_q.rdata <= rd_data;      // Data seen during the grant cycle
            end
        end
    end

    assign link_grant = link_win;
    assign host_gnt   = host_win;
    assign bank_req   = bank_q;
    assign host_rsp   = rsp_q;

endmodule

// ==== logic/reg_bus_pkg.sv ====
`include "esp_link_cfg.svh"

// Register bank side of the subsystem
package reg_bus_pkg;

    typedef logic [`ESP_ADDR_W-1:0] reg_addr_t;  // Bank address
    typedef logic [`ESP_WORD_W-1:0] reg_word_t;  // Bank data word

    // Host access, held until granted
    typedef struct packed {
        logic      valid;  // Request pending
        logic      write;  // 1 write, 0 read
        logic      lock;   // Keep the bank for the next access
        reg_addr_t addr;
        reg_word_t wdata;
    } host_req_t;

    // Read return one cycle after the grant
    typedef struct packed {
        logic      valid;
        reg_word_t rdata;
    } host_rsp_t;

    // Single access issued to the bank each cycle
    typedef struct packed {
        logic      valid;
        logic      write;  // Reads leave the array untouched
        reg_addr_t addr;
        reg_word_t data;
    } bank_wr_t;

    // Layout of register 0
    typedef struct packed {
        logic                                     overrun;     // Sticky drop flag
        logic [`ESP_WORD_W-`ESP_COUNT_W-2:0]      reserved;    // Reads as zero
        logic [`ESP_COUNT_W-1:0]                  word_count;  // Saturating
    } status_t;

endpackage

// ==== logic/write_credit_queue.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module write_credit_queue #(
    parameter int DEPTH = `ESP_CREDITS  // Must match the credits handed out
) (
    input  logic                   clk,
    input  logic                   nrst,
    input  esp_link_pkg::word_wr_t push,           // valid is the write strobe
    output esp_link_pkg::word_wr_t head,           // valid means not empty
    input  logic                   pop,            // Grant from the arbiter
    output logic                   credit_return   // One pulse per entry drained
);
    import esp_link_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_wr_t           mem [DEPTH];  // Entry storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;        // Entries held
    logic               do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    assign do_pop = pop && (count != '0);  // Ignore a stray pop when empty

    // Credits bound the pushes so no full check here
    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push.valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count         <= count + CNT_W'(push.valid) - CNT_W'(do_pop);
            credit_return <= do_pop;  // Slot is free again next cycle
        end
    end

    always_comb begin
        head       = mem[rd_ptr];
        head.valid = (count != '0);  // Stored valid bit is not trusted
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/esp_link_pkg.sv
logic/reg_bus_pkg.sv
logic/esp_word_assembler.sv
logic/write_credit_queue.sv
logic/reg_bank_arbiter.sv
logic/reg_bank.sv
logic/esp_link_top.sv
verification/tb_esp_link.sv

// ==== verification/tb_esp_link.sv ====
`timescale 1ns/1ps
`include "esp_link_cfg.svh"

module tb_esp_link;
    import esp_link_pkg::*;
    import reg_bus_pkg::*;

    localparam int WAIT_LIMIT = 200;                  // Cycles before any wait gives up
    localparam int LAST_ADDR  = `ESP_REG_COUNT - 1;   // Highest link address

    logic      clk;
    logic      nrst;
    esp_byte_t esp_data;
    logic      esp_cs;
    host_req_t host_req;
    logic      host_gnt;
    host_rsp_t host_rsp;
    logic      link_busy;

    logic [`ESP_WORD_W-1:0]  model_regs [`ESP_REG_COUNT];  // Expected bank contents
    logic [`ESP_COUNT_W-1:0] model_count;                   // Expected stored words
    logic                    model_overrun;                 // Expected sticky flag
    logic [`ESP_WORD_W-1:0]  sent_word [64];                // Words of the last frame
    logic [`ESP_ADDR_W-1:0]  sent_addr [64];                // Where each one should land
    logic [31:0]             lcg_state = 32'h6e4a398b;
    int                      mismatch_count = 0;
    int                      fail_count = 0;

    esp_link_top u_dut (
        .clk       (clk),
        .nrst      (nrst),
        .esp_data  (esp_data),
        .esp_cs    (esp_cs),
        .host_req  (host_req),
        .host_gnt  (host_gnt),
        .host_rsp  (host_rsp),
        .link_busy (link_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Read data shows up exactly one cycle after a read grant
    rsp_after_read_grant: assert property (@(posedge clk) disable iff (!nrst)
        (host_gnt && !host_req.write) |=> host_rsp.valid)
    else begin
        fail_count++;
        $display("host_rsp valid missing on the cycle after a read grant");
    end

    rsp_only_from_grant: assert property (@(posedge clk) disable iff (!nrst)
        host_rsp.valid |-> $past(host_gnt && !host_req.write))
    else begin
        fail_count++;
        $display("host_rsp valid high without a read grant one cycle before");
    end

    one_grant_per_cycle: assert property (@(posedge clk) disable iff (!nrst)
        !(host_gnt && u_dut.link_grant))
    else begin
        fail_count++;
        $display("host and link were granted the bank in the same cycle");
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
        return lcg_state;
    endfunction

    function automatic logic [`ESP_ADDR_W-1:0] step_addr(input logic [`ESP_ADDR_W-1:0] a);
        return (a == `ESP_ADDR_W'(LAST_ADDR)) ? `ESP_ADDR_W'(1) : a + `ESP_ADDR_W'(1);
    endfunction

    function automatic logic [31:0] expected_status();
        return {model_overrun, {(`ESP_WORD_W-`ESP_COUNT_W-1){1'b0}}, model_count};
    endfunction

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        fail_count++;
        $display("timeout while waiting for %s", what);
        report_counts();
        $display("TB FAILED");
        $finish;
    endtask

    // Returns at the negedge of the grant cycle
    task automatic wait_grant();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!host_gnt) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("host_gnt");
        end
    endtask

    // Idle means low for three samples, which spans the push gap
    task automatic wait_link_idle();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < 3) begin
            @(negedge clk);
            quiet = link_busy ? 0 : quiet + 1;
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("link_busy to fall");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        esp_cs   = 1'b0;
        esp_data = b;
        @(posedge clk);
        #1;
    endtask

    // Frame of n words, tail_bytes of an unfinished word, then chip select high
    task automatic send_frame(input int n, input int tail_bytes);
        logic [31:0]            w;
        logic [`ESP_ADDR_W-1:0] a;
        a = `ESP_ADDR_W'(1);  // Every frame starts at address 1
        for (int k = 0; k < n; k++) begin
            w            = next_random();
            sent_word[k] = w;
            sent_addr[k] = a;
            for (int b = 3; b >= 0; b--) begin
                send_byte(w[8*b +: 8]);  // MSB first
                if (b == 3) begin
                    check_value("link_busy", 32'(link_busy), 32'h1);  // One byte held
                end
            end
            a = step_addr(a);
        end
        for (int b = 0; b < tail_bytes; b++) begin
            w = next_random();
            send_byte(w[7:0]);
        end
        esp_cs = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic store_frame(input int n);
        for (int k = 0; k < n; k++) begin
            model_regs[sent_addr[k]] = sent_word[k];
            model_count++;
        end
    endtask

    task automatic host_access(input logic wr, input logic [`ESP_ADDR_W-1:0] a,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        host_req.valid = 1'b1;
        host_req.write = wr;
        host_req.lock  = 1'b0;
        host_req.addr  = a;
        host_req.wdata = wdata;
        wait_grant();
        @(posedge clk);          // Grant edge
        #1;
        rdata          = host_rsp.rdata;
        host_req.valid = 1'b0;
    endtask

    task automatic check_range(input int lo, input int hi);
        logic [31:0] got;
        for (int a = lo; a <= hi; a++) begin
            host_access(1'b0, `ESP_ADDR_W'(a), 32'h0, got);
            check_value($sformatf("host_rsp.rdata[%0d]", a), got, model_regs[a]);
        end
    endtask

    task automatic check_status();
        logic [31:0] got;
        host_access(1'b0, '0, 32'h0, got);
        check_value("status", got, expected_status());
    endtask

    // Valid stays high between accesses so the lock never lapses
    task automatic locked_reads(input int n);
        logic [`ESP_ADDR_W-1:0] a;
        logic [31:0]            got;
        a              = `ESP_ADDR_W'(1);
        host_req.valid = 1'b1;
        host_req.write = 1'b0;
        host_req.lock  = 1'b1;
        host_req.addr  = a;
        host_req.wdata = 32'h0;
        for (int i = 0; i < n; i++) begin
            wait_grant();
            @(posedge clk);
            #1;
            got = host_rsp.rdata;
            check_value($sformatf("host_rsp.rdata[%0d] locked", a), got, model_regs[a]);
            a             = step_addr(a);
            host_req.addr = a;
        end
        host_req.valid = 1'b0;
        host_req.lock  = 1'b0;
    endtask

    initial begin
        logic [31:0]             got;
        logic [31:0]             w;
        logic [`ESP_ADDR_W-1:0]  a;
        logic [`ESP_COUNT_W-1:0] base;
        logic [`ESP_COUNT_W-1:0] delta;
        nrst          = 1'b0;
        esp_cs        = 1'b1;
        esp_data      = '0;
        host_req      = '0;
        model_count   = '0;
        model_overrun = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        nrst = 1'b1;
        check_value("host_gnt", 32'(host_gnt), 32'h0);
        check_value("host_rsp.valid", 32'(host_rsp.valid), 32'h0);
        check_status();                                  // Count and overrun clear

        send_frame(10, 0);                               // Burst storage
        store_frame(10);
        wait_link_idle();
        check_range(1, 10);

        send_frame(33, 2);                               // Wrap, then an aborted word
        store_frame(33);
        wait_link_idle();
        check_range(1, LAST_ADDR);
        send_frame(1, 0);                                // Restart lands at address 1
        store_frame(1);
        wait_link_idle();
        check_range(1, 3);

        check_status();
        host_access(1'b1, '0, next_random(), got);       // Status is read only
        check_status();

        repeat (6) begin                                 // Host round trip
            w = next_random();
            a = `ESP_ADDR_W'(w % 31) + `ESP_ADDR_W'(1);
            w = next_random();
            host_access(1'b1, a, w, got);
            model_regs[a] = w;
        end
        check_range(1, LAST_ADDR);

        base = model_count;                              // Overrun under host lock
        fork
            locked_reads(40);
            begin
                @(posedge clk);
                #1;
                send_frame(12, 0);
            end
        join
        wait_link_idle();
        host_access(1'b0, '0, 32'h0, got);
        check_value("status.overrun", 32'(got[`ESP_WORD_W-1]), 32'h1);
        delta = got[`ESP_COUNT_W-1:0] - base;
        assert (delta >= `ESP_CREDITS && delta < 12) else begin
            mismatch_count++;
            $display("mismatch status.word_count: grew by %h expected %h to %h",
                     delta, `ESP_CREDITS, 11);
        end
        model_overrun = 1'b1;
        for (int k = 0; k < 12; k++) begin
            a = sent_addr[k];
            host_access(1'b0, a, 32'h0, got);
            assert (got === sent_word[k] || got === model_regs[a]) else begin
                mismatch_count++;
                $display("mismatch host_rsp.rdata[%0d]: got %h expected %h or %h",
                         a, got, sent_word[k], model_regs[a]);
            end
            if (got === sent_word[k]) begin
                model_count++;                           // This word reached the bank
            end
            model_regs[a] = got;                         // Either value is legal
        end
        check_status();

        report_counts();
        if (mismatch_count + fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
